// ==== list.f ====
common/fc_pkg.sv
event_unit/event_fifo.sv
event_unit/irq_regfile.sv
event_unit/irq_arbiter.sv
verilog/core_irq_bridge.sv
verilog/fc_subsystem.sv
verification/fc_subsystem_tb.sv

// ==== verification/fc_subsystem_tb.sv ====
/*
 * Table-driven testbench for the event unit, playing the
 * event sources, software and core
 */
`timescale 1ns/1ns
`default_nettype none

module fc_subsystem_tb
    import fc_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int TIMEOUT    = 50;

    typedef enum {
        ACT_EVENT, ACT_PUSH, ACT_WRITE, ACT_READ, ACT_WAIT_IRQ,
        ACT_ACK, ACT_STATUS, ACT_FETCH, ACT_IDLE
    } act_e;

    typedef struct {
        act_e        act;
        fc_reg_e     addr;
        logic [31:0] value;
        logic [31:0] expected;
        string       name;
    } step_t;

    logic             clk = 1'b0;
    logic             arst_n;
    logic [N_IRQ-1:0] events;
    logic             fifo_valid;
    logic [7:0]       fifo_data;
    logic             fifo_fulln;
    fc_reg_req_t      reg_req;
    logic [31:0]      reg_rdata;
    fc_irq_ack_t      irq_ack;
    fc_irq_req_t      core_irq;
    logic [N_IRQ-1:0] core_irq_x;
    logic             clock_en;
    logic             fetch_en_in;
    logic             fetch_en_out;
    step_t            steps[$];
    integer           seed;

    always #5 clk = ~clk;

    fc_subsystem #(
        .CORE_TYPE      ( 1          ),
        .EVENT_ID_WIDTH ( 8          ),
        .FIFO_DEPTH     ( FIFO_DEPTH )
    ) fc_subsystem_inst (
        .clk_i              ( clk          ),
        .arst_n_i           ( arst_n       ),
        .events_i           ( events       ),
        .event_fifo_valid_i ( fifo_valid   ),
        .event_fifo_data_i  ( fifo_data    ),
        .event_fifo_fulln_o ( fifo_fulln   ),
        .reg_req_i          ( reg_req      ),
        .reg_rdata_o        ( reg_rdata    ),
        .core_irq_ack_i     ( irq_ack      ),
        .core_irq_o         ( core_irq     ),
        .core_irq_x_o       ( core_irq_x   ),
        .core_clock_en_o    ( clock_en     ),
        .fetch_en_i         ( fetch_en_in  ),
        .fetch_en_o         ( fetch_en_out )
    );

    //********************
    // Checks
    //********************
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                     name, exp_val, act_val));
        end
    endtask

    task automatic check_irq(input string name, input fc_irq_req_t exp_val,
                             input fc_irq_req_t act_val);
        if (act_val !== exp_val) begin
            report_failure($sformatf("mismatch %s: expected req %b id %0d, actual req %b id %0d",
                                     name, exp_val.req, exp_val.id, act_val.req, act_val.id));
        end
    endtask

    task automatic check_vec(input string name, input logic [N_IRQ-1:0] exp_val,
                             input logic [N_IRQ-1:0] act_val);
        if (act_val !== exp_val) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                     name, exp_val, act_val));
        end
    endtask

    //********************
    // Step table
    //********************
    task automatic add_step(input act_e act, input fc_reg_e addr, input logic [31:0] value,
                            input logic [31:0] expected, input string name);
        step_t s;
        s.act      = act;
        s.addr     = addr;
        s.value    = value;
        s.expected = expected;
        s.name     = name;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] pend;
        logic [31:0] mask;
        logic [31:0] pat;
        logic [7:0]  ids[FIFO_DEPTH];
        // Status word is {clock enable, fulln, request}
        add_step(ACT_STATUS, REG_MASK, 0, 3'b110, "reset status");
        add_step(ACT_READ, REG_MASK, 0, 0, "reset mask");
        add_step(ACT_READ, REG_PENDING, 0, 0, "reset pending");
        add_step(ACT_FETCH, REG_CTRL, 0, 0, "fetch gate with pad low");
        add_step(ACT_FETCH, REG_CTRL, 1, 1, "fetch gate with pad high");

        // Random events while everything is masked
        pend = '0;
        for (int i = 0; i < 3; i++) begin
            pat  = $random(seed);
            pend = pend | pat;
            add_step(ACT_EVENT, REG_MASK, pat, 0, "event pulse");
        end
        add_step(ACT_READ, REG_PENDING, 0, pend, "pending after events");
        add_step(ACT_STATUS, REG_MASK, 0, 3'b110, "no request while masked");
        pat  = $random(seed);
        pend = pend & ~pat;
        add_step(ACT_WRITE, REG_PENDING_CLR, pat, 0, "pending clear");
        add_step(ACT_READ, REG_PENDING, 0, pend, "pending after clear");

        // Unmasked lines come out highest index first
        mask = $random(seed);
        add_step(ACT_WRITE, REG_MASK, mask, 0, "mask write");
        add_step(ACT_READ, REG_MASK, 0, mask, "mask readback");
        for (int i = N_IRQ - 1; i >= 0; i--) begin
            if (pend[i] && mask[i]) begin
                pend[i] = 1'b0;
                add_step(ACT_WAIT_IRQ, REG_MASK, i, 0, $sformatf("request line %0d", i));
                add_step(ACT_ACK, REG_MASK, i, 0, "ack");
                add_step(ACT_READ, REG_PENDING, 0, pend, $sformatf("pending after ack %0d", i));
            end
        end
        add_step(ACT_STATUS, REG_MASK, 0, 3'b110, "no request after acks");
        add_step(ACT_WRITE, REG_PENDING_CLR, 32'hffff_ffff, 0, "pending clear all");
        add_step(ACT_WRITE, REG_MASK, 0, 0, "mask clear");
        add_step(ACT_READ, REG_PENDING, 0, 0, "pending empty");

        //********************
        // Event FIFO
        //********************
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            ids[i] = $random(seed);
            add_step(ACT_PUSH, REG_FIFO, ids[i], 0, "fifo push");
        end
        add_step(ACT_STATUS, REG_MASK, 0, 3'b100, "fifo full");
        add_step(ACT_WRITE, REG_MASK, 32'b1 << FIFO_EVT_LINE, 0, "unmask fifo line");
        add_step(ACT_WAIT_IRQ, REG_MASK, FIFO_EVT_LINE, 0, "fifo line request");
        add_step(ACT_ACK, REG_MASK, FIFO_EVT_LINE, 0, "ack with entries left");
        add_step(ACT_WAIT_IRQ, REG_MASK, FIFO_EVT_LINE, 0, "fifo line request again");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_step(ACT_READ, REG_FIFO, 0, 32'(ids[i]), $sformatf("fifo pop %0d", i));
        end
        add_step(ACT_READ, REG_FIFO, 0, 0, "pop on empty fifo");
        add_step(ACT_STATUS, REG_MASK, 0, 3'b111, "request held after drain");
        add_step(ACT_ACK, REG_MASK, FIFO_EVT_LINE, 0, "ack drained fifo");
        add_step(ACT_READ, REG_PENDING, 0, 0, "pending after drain");
        add_step(ACT_STATUS, REG_MASK, 0, 3'b110, "fifo line quiet");

        // Sleep, wake on an unmasked event, then stop fetching
        add_step(ACT_WRITE, REG_CTRL, 32'h3, 0, "sleep request");
        add_step(ACT_STATUS, REG_MASK, 0, 3'b010, "clock gated");
        add_step(ACT_WRITE, REG_MASK, 32'b1 << 9, 0, "unmask line 9");
        add_step(ACT_EVENT, REG_MASK, 32'b1 << 9, 0, "wake event");
        add_step(ACT_WAIT_IRQ, REG_MASK, 9, 0, "wake request");
        add_step(ACT_STATUS, REG_MASK, 0, 3'b011, "clock still gated");
        add_step(ACT_IDLE, REG_MASK, 1, 0, "wake edge");
        add_step(ACT_STATUS, REG_MASK, 0, 3'b111, "clock back on");
        add_step(ACT_ACK, REG_MASK, 9, 0, "ack wake");
        add_step(ACT_WRITE, REG_CTRL, 0, 0, "fetch enable off");
        add_step(ACT_FETCH, REG_CTRL, 1, 0, "fetch gated by software");
        add_step(ACT_READ, REG_CTRL, 0, 0, "ctrl readback");
    endtask

    task automatic run_step(input step_t s);
        fc_irq_req_t exp_irq;
        int          cnt;
        cnt = 0;
        case (s.act)
            ACT_EVENT: begin
                events = s.value;
                @(negedge clk);
                events = '0;
            end
            ACT_PUSH: begin
                while (!fifo_fulln) begin
                    if (cnt == TIMEOUT) begin
                        report_failure($sformatf("%s: FIFO stayed full", s.name));
                    end
                    cnt++;
                    @(negedge clk);
                end
                fifo_valid = 1'b1;
                fifo_data  = s.value[7:0];
                @(negedge clk);
                fifo_valid = 1'b0;
            end
            ACT_WRITE, ACT_READ: begin
                reg_req.req   = 1'b1;
                reg_req.we    = (s.act == ACT_WRITE);
                reg_req.addr  = s.addr;
                reg_req.wdata = s.value;
                @(negedge clk);
                reg_req = '0;
                if (s.act == ACT_READ) begin
                    check_word(s.name, s.expected, reg_rdata);
                end
            end
            ACT_WAIT_IRQ: begin
                while (!core_irq.req) begin
                    if (cnt == TIMEOUT) begin
                        report_failure($sformatf("%s: no interrupt request arrived", s.name));
                    end
                    cnt++;
                    @(negedge clk);
                end
                exp_irq.req = 1'b1;
                exp_irq.id  = fc_irq_id_t'(s.value);
                check_irq(s.name, exp_irq, core_irq);
                check_vec(s.name, 32'b1 << s.value, core_irq_x);
            end
            ACT_ACK: begin
                irq_ack.ack = 1'b1;
                irq_ack.id  = fc_irq_id_t'(s.value);
                @(negedge clk);
                irq_ack = '0;
            end
            ACT_STATUS: check_word(s.name, s.expected, {29'b0, clock_en, fifo_fulln, core_irq.req});
            ACT_FETCH: begin
                fetch_en_in = s.value[0];
                @(negedge clk);
                check_word(s.name, s.expected, {31'b0, fetch_en_out});
            end
            ACT_IDLE: repeat (s.value) @(negedge clk);
            default: report_failure("unknown action in the step table");
        endcase
    endtask

    initial begin
        seed        = 32'hb8da_c4a9;
        arst_n      = 1'b0;
        events      = '0;
        fifo_valid  = 1'b0;
        fifo_data   = '0;
        reg_req     = '0;
        irq_ack     = '0;
        fetch_en_in = 1'b1;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fc_subsystem.sv ====
/*
 * Event unit top with the event FIFO, register file,
 * arbiter and core bridge
 */
`timescale 1ns/1ns
`default_nettype none

module fc_subsystem
    import fc_pkg::*;
#(
    parameter int CORE_TYPE      = 0,
    parameter int EVENT_ID_WIDTH = fc_pkg::EVENT_ID_WIDTH,
    parameter int FIFO_DEPTH     = 8
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    // Event sources
    input  logic [N_IRQ-1:0]          events_i,
    input  logic                      event_fifo_valid_i,
    input  logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,
    output logic                      event_fifo_fulln_o,

    // Software register port
    input  fc_reg_req_t               reg_req_i,
    output logic [31:0]               reg_rdata_o,

    // Core
    input  fc_irq_ack_t               core_irq_ack_i,
    output fc_irq_req_t               core_irq_o,
    output logic [N_IRQ-1:0]          core_irq_x_o,
    output logic                      core_clock_en_o,
    input  logic                      fetch_en_i,
    output logic                      fetch_en_o
);

    logic                      fifo_nonempty;
    logic                      fifo_pop;
    logic [EVENT_ID_WIDTH-1:0] fifo_data;
    logic [N_IRQ-1:0]          masked_pending;
    logic                      fetch_en_eu;
    logic                      sleep_req;

    // Boot gate from the pad and from software
    assign fetch_en_o = fetch_en_i & fetch_en_eu;

    //********************
    // Event unit
    //********************
    event_fifo #(
        .DEPTH          ( FIFO_DEPTH     ),
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH )
    ) event_fifo_inst (
        .clk_i       ( clk_i              ),
        .arst_n_i    ( arst_n_i           ),
        .evt_valid_i ( event_fifo_valid_i ),
        .evt_data_i  ( event_fifo_data_i  ),
        .evt_fulln_o ( event_fifo_fulln_o ),
        .pop_i       ( fifo_pop           ),
        .pop_data_o  ( fifo_data          ),
        .nonempty_o  ( fifo_nonempty      )
    );

    irq_regfile #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH )
    ) irq_regfile_inst (
        .clk_i            ( clk_i          ),
        .arst_n_i         ( arst_n_i       ),
        .reg_req_i        ( reg_req_i      ),
        .reg_rdata_o      ( reg_rdata_o    ),
        .events_i         ( events_i       ),
        .fifo_nonempty_i  ( fifo_nonempty  ),
        .fifo_data_i      ( fifo_data      ),
        .fifo_pop_o       ( fifo_pop       ),
        .irq_ack_i        ( core_irq_ack_i ),
        .masked_pending_o ( masked_pending ),
        .fetch_en_o       ( fetch_en_eu    ),
        .sleep_req_o      ( sleep_req      )
    );

    irq_arbiter irq_arbiter_inst (
        .clk_i            ( clk_i          ),
        .arst_n_i         ( arst_n_i       ),
        .masked_pending_i ( masked_pending ),
        .irq_ack_i        ( core_irq_ack_i ),
        .irq_o            ( core_irq_o     )
    );

    core_irq_bridge #(
        .CORE_TYPE ( CORE_TYPE )
    ) core_irq_bridge_inst (
        .clk_i       ( clk_i           ),
        .arst_n_i    ( arst_n_i        ),
        .irq_i       ( core_irq_o      ),
        .sleep_req_i ( sleep_req       ),
        .irq_x_o     ( core_irq_x_o    ),
        .clock_en_o  ( core_clock_en_o )
    );

endmodule

`default_nettype wire

// ==== verilog/core_irq_bridge.sv ====
/*
 * Core-facing side with the one-hot interrupt vector
 * and the sleep/wake core clock enable
 */
`timescale 1ns/1ns
`default_nettype none

module core_irq_bridge
    import fc_pkg::*;
#(
    parameter int CORE_TYPE = 0
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  fc_irq_req_t      irq_i,
    input  logic             sleep_req_i,
    output logic [N_IRQ-1:0] irq_x_o,
    output logic             clock_en_o
);

    fc_sleep_e state_q;
    fc_sleep_e state_d;

    // Ibex reads the lines directly, ID-based cores get nothing here
    always_comb begin
        irq_x_o = '0;
        if (CORE_TYPE == 1 && irq_i.req) begin
            irq_x_o[irq_i.id] = 1'b1;
        end
    end

    //********************
    // Sleep FSM
    //********************
    always_comb begin
        state_d = state_q;
        case (state_q)
            SLEEP_RUN: begin
                if (sleep_req_i) begin
                    state_d = SLEEP_IDLE;
                end
            end
            SLEEP_IDLE: begin
                // Any request wakes the core
                if (irq_i.req) begin
                    state_d = SLEEP_RUN;
                end
            end
            default: state_d = SLEEP_RUN;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= SLEEP_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign clock_en_o = (state_q == SLEEP_RUN);

    a_irq_x_onehot: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) $onehot0(irq_x_o)
    );

endmodule

`default_nettype wire

// ==== event_unit/irq_arbiter.sv ====
/*
 * Picks the highest pending unmasked line and holds it as the
 * core request until the core acknowledges it
 */
`timescale 1ns/1ns
`default_nettype none

module irq_arbiter
    import fc_pkg::*;
(
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [N_IRQ-1:0] masked_pending_i,
    input  fc_irq_ack_t      irq_ack_i,
    output fc_irq_req_t      irq_o
);

    fc_irq_req_t irq_q;
    fc_irq_id_t  sel_id;
    logic        sel_valid;

    //********************
    // Priority encoder
    //********************
    // Higher index wins, so the last set bit in the scan is kept
    always_comb begin
        sel_valid = |masked_pending_i;
        sel_id    = '0;
        for (int i = 0; i < N_IRQ; i++) begin
            if (masked_pending_i[i]) begin
                sel_id = fc_irq_id_t'(i);
            end
        end
    end

    //********************
    // Request register
    //********************
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_q <= '0;
        end else if (irq_ack_i.ack) begin
            // One idle cycle lets pending settle before the next pick
            irq_q.req <= 1'b0;
        end else if (!irq_q.req) begin
            irq_q.req <= sel_valid;
            irq_q.id  <= sel_id;
        end
    end

    assign irq_o = irq_q;

    // An open request keeps its id until the core takes it
    a_id_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        irq_q.req && !irq_ack_i.ack |=> irq_q.req && $stable(irq_q.id)
    );

endmodule

`default_nettype wire

// ==== event_unit/irq_regfile.sv ====
/*
 * Mask, pending and control registers behind the software
 * register port, with FIFO pop and acknowledge clearing
 */
`timescale 1ns/1ns
`default_nettype none

module irq_regfile
    import fc_pkg::*;
#(
    parameter int EVENT_ID_WIDTH = fc_pkg::EVENT_ID_WIDTH
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  fc_reg_req_t               reg_req_i,
    output logic [31:0]               reg_rdata_o,
    input  logic [N_IRQ-1:0]          events_i,
    input  logic                      fifo_nonempty_i,
    input  logic [EVENT_ID_WIDTH-1:0] fifo_data_i,
    output logic                      fifo_pop_o,
    input  fc_irq_ack_t               irq_ack_i,
    output logic [N_IRQ-1:0]          masked_pending_o,
    output logic                      fetch_en_o,
    output logic                      sleep_req_o
);

    logic [N_IRQ-1:0] mask_q;
    logic [N_IRQ-1:0] pending_q;
    logic [N_IRQ-1:0] pending_d;
    logic             fetch_en_q;
    logic             reg_wr;
    logic             reg_rd;
    logic [N_IRQ-1:0] sw_set;
    logic [N_IRQ-1:0] sw_clr;
    logic [N_IRQ-1:0] ack_clr;
    logic [N_IRQ-1:0] fifo_line;
    logic [N_IRQ-1:0] hw_set;
    logic [31:0]      rdata_d;

    assign reg_wr = reg_req_i.req & reg_req_i.we;
    assign reg_rd = reg_req_i.req & ~reg_req_i.we;

    assign fifo_pop_o  = reg_rd && (reg_req_i.addr == REG_FIFO);
    assign sleep_req_o = reg_wr && (reg_req_i.addr == REG_CTRL) && reg_req_i.wdata[1];

    assign masked_pending_o = pending_q & mask_q;
    assign fetch_en_o       = fetch_en_q;

    //********************
    // Pending update
    //********************
    always_comb begin
        sw_set    = '0;
        sw_clr    = '0;
        ack_clr   = '0;
        fifo_line = '0;
        if (reg_wr && reg_req_i.addr == REG_PENDING_SET) begin
            sw_set = reg_req_i.wdata;
        end
        if (reg_wr && reg_req_i.addr == REG_PENDING_CLR) begin
            sw_clr = reg_req_i.wdata;
        end
        if (irq_ack_i.ack) begin
            ack_clr[irq_ack_i.id] = 1'b1;
        end
        fifo_line[FIFO_EVT_LINE] = fifo_nonempty_i;
    end

    // Hardware sources win over any clear in the same cycle
    assign hw_set    = events_i | fifo_line;
    assign pending_d = ((pending_q | hw_set | sw_set) & ~(ack_clr | sw_clr)) | hw_set;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q     <= '0;
            pending_q  <= '0;
            fetch_en_q <= 1'b1;
        end else begin
            pending_q <= pending_d;
            if (reg_wr) begin
                case (reg_req_i.addr)
                    REG_MASK:     mask_q     <= reg_req_i.wdata;
                    REG_MASK_SET: mask_q     <= mask_q | reg_req_i.wdata;
                    REG_MASK_CLR: mask_q     <= mask_q & ~reg_req_i.wdata;
                    REG_CTRL:     fetch_en_q <= reg_req_i.wdata[0];
                    default:      mask_q     <= mask_q;
                endcase
            end
        end
    end

    //********************
    // Read data
    //********************
    always_comb begin
        case (reg_req_i.addr)
            REG_MASK, REG_MASK_SET, REG_MASK_CLR:          rdata_d = mask_q;
            REG_PENDING, REG_PENDING_SET, REG_PENDING_CLR: rdata_d = pending_q;
            REG_FIFO:                                      rdata_d = 32'(fifo_data_i);
            REG_CTRL:                                      rdata_d = {31'b0, fetch_en_q};
            default:                                       rdata_d = '0;
        endcase
    end

    // Valid one clock after the read request
    always_ff @(posedge clk_i) begin
        if (reg_rd) begin
            reg_rdata_o <= rdata_d;
        end
    end

endmodule

`default_nettype wire

// ==== event_unit/event_fifo.sv ====
/*
 * Circular buffer for peripheral event ids, with back-pressure
 * and a non-empty flag that feeds one interrupt line
 */
`timescale 1ns/1ns
`default_nettype none

module event_fifo #(
    parameter int DEPTH          = 8,
    parameter int EVENT_ID_WIDTH = 8
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      evt_valid_i,
    input  logic [EVENT_ID_WIDTH-1:0] evt_data_i,
    output logic                      evt_fulln_o,
    input  logic                      pop_i,
    output logic [EVENT_ID_WIDTH-1:0] pop_data_o,
    output logic                      nonempty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [EVENT_ID_WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]          wptr_q;
    logic [PTR_W-1:0]          rptr_q;
    logic [CNT_W-1:0]          count_q;
    logic                      push;
    logic                      pop;

    assign nonempty_o  = (count_q != '0);
    assign evt_fulln_o = (count_q != CNT_W'(DEPTH));

    // Source holds its event while fulln is low
    assign push = evt_valid_i & evt_fulln_o;
    assign pop  = pop_i & nonempty_o;

    // Oldest entry, zero when there is nothing to pop
    assign pop_data_o = nonempty_o ? mem_q[rptr_q] : '0;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_q] <= evt_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Never more entries than slots
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) count_q <= CNT_W'(DEPTH)
    );

endmodule

`default_nettype wire

// ==== common/fc_pkg.sv ====
/*
 * Shared widths, register opcodes, sleep states and the
 * register-port and interrupt structs of the event unit
 */
`default_nettype none

package fc_pkg;

    // Interrupt lines seen by the core
    localparam int N_IRQ = 32;

    // Default width of a peripheral event id
    localparam int EVENT_ID_WIDTH = 8;

    // Line that stays pending while the event FIFO holds entries
    localparam int FIFO_EVT_LINE = 26;

    typedef logic [4:0] fc_irq_id_t;

    //********************
    // Register port
    //********************
    typedef enum logic [2:0] {
        REG_MASK        = 3'd0,
        REG_MASK_SET    = 3'd1,
        REG_MASK_CLR    = 3'd2,
        REG_PENDING     = 3'd3,
        REG_PENDING_SET = 3'd4,
        REG_PENDING_CLR = 3'd5,
        REG_FIFO        = 3'd6,
        REG_CTRL        = 3'd7
    } fc_reg_e;

    typedef struct packed {
        logic        req;
        logic        we;
        fc_reg_e     addr;
        logic [31:0] wdata;
    } fc_reg_req_t;

    //********************
    // Core side
    //********************
    typedef struct packed {
        logic       req;
        fc_irq_id_t id;
    } fc_irq_req_t;

    typedef struct packed {
        logic       ack;
        fc_irq_id_t id;
    } fc_irq_ack_t;

    // Core clock gating
    typedef enum logic {
        SLEEP_RUN  = 1'b0,
        SLEEP_IDLE = 1'b1
    } fc_sleep_e;

endpackage

`default_nettype wire
